// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_isp_focus
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
source/isp_pkg.sv
source/gray_lane.sv
source/gray_buffer.sv
source/frame_sequencer.sv
source/focus_window.sv
source/isp_focus_top.sv
tb/isp_focus_asserts.sv
tb/tb_isp_focus.sv

// ==== source/focus_window.sv ====
`timescale 1ns/1ps
`default_nettype none

module focus_window import isp_pkg::*; #(
    parameter int win_row = 13,
    parameter int win_col = 10
) (
    input  logic          clk,
    input  logic          rst_n,
    input  lane_ctrl_t    ctrl,
    input  beat_t         gray_beat,
    output logic          out_valid,
    output focus_result_t out_focus
);

    localparam int beats_per_row = img_w / lanes;
    localparam int first_beat    = win_row * beats_per_row + win_col / lanes;
    localparam int lane_off      = win_col % lanes;
    localparam int centre        = win_size / 2;
    // 2x2, 4x4 and 6x6
    localparam int n_windows     = 3;

    pixel_t    win [win_size][win_size];
    contrast_t h_sum [n_windows];
    contrast_t v_sum [n_windows];
    contrast_t h_q [n_windows];
    contrast_t v_q [n_windows];
    logic      sum_valid;

    function automatic pixel_t abs_diff(pixel_t a, pixel_t b);
        return (a > b) ? a - b : b - a;
    endfunction

    // index span lo..hi lies inside nested window k
    function automatic logic in_window(int k, int lo, int hi);
        return (lo >= centre - 1 - k) && (hi <= centre + k);
    endfunction

    // ========================================================================
    // window capture during the blue pass
    // ========================================================================
    always_ff @(posedge clk) begin
        if (ctrl.valid && ctrl.channel == ch_blue) begin
            for (int r = 0; r < win_size; r++) begin
                if (ctrl.beat == beat_idx_t'(first_beat + r * beats_per_row)) begin
                    for (int c = 0; c < win_size; c++) begin
                        win[r][c] <= gray_beat[lane_off + c];
                    end
                end
            end
        end
    end

    // ========================================================================
    // contrast sums
    // ========================================================================
    always_comb begin
        for (int k = 0; k < n_windows; k++) begin
            h_sum[k] = '0;
            v_sum[k] = '0;
        end
        // horizontal neighbours
        for (int r = 0; r < win_size; r++) begin
            for (int c = 0; c < win_size - 1; c++) begin
                for (int k = 0; k < n_windows; k++) begin
                    if (in_window(k, r, r) && in_window(k, c, c + 1)) begin
                        h_sum[k] = h_sum[k] + contrast_t'(abs_diff(win[r][c], win[r][c + 1]));
                    end
                end
            end
        end
        // vertical neighbours
        for (int r = 0; r < win_size - 1; r++) begin
            for (int c = 0; c < win_size; c++) begin
                for (int k = 0; k < n_windows; k++) begin
                    if (in_window(k, r, r + 1) && in_window(k, c, c)) begin
                        v_sum[k] = v_sum[k] + contrast_t'(abs_diff(win[r][c], win[r + 1][c]));
                    end
                end
            end
        end
    end

    // first stage holds the split sums, second adds them
    always_ff @(posedge clk) begin
        if (ctrl.last) begin
            h_q <= h_sum;
            v_q <= v_sum;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sum_valid <= 1'b0;
            out_valid <= 1'b0;
            out_focus <= '0;
        end else begin
            sum_valid <= ctrl.last;
            out_valid <= sum_valid;
            if (sum_valid) begin
                out_focus.contrast_2 <= h_q[0] + v_q[0];
                out_focus.contrast_4 <= h_q[1] + v_q[1];
                out_focus.contrast_6 <= h_q[2] + v_q[2];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/frame_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_sequencer import isp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       in_valid,
    output lane_ctrl_t ctrl
);

    localparam beat_idx_t last_beat = beat_idx_t'(beats_per_channel - 1);

    beat_idx_t beat_q;
    channel_t  chan_q;
    logic      beat_wrap;

    assign beat_wrap = (beat_q == last_beat);

    // ========================================================================
    // beat and channel counters
    // ========================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            beat_q <= '0;
        end else if (in_valid) begin
            if (beat_wrap) begin
                beat_q <= '0;
            end else begin
                beat_q <= beat_q + 1'b1;
            end
        end
    end

    // red -> green -> blue, then back to red for the next picture
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chan_q <= ch_red;
        end else if (in_valid && beat_wrap) begin
            if (chan_q == ch_blue) begin
                chan_q <= ch_red;
            end else begin
                chan_q <= chan_q + 1'b1;
            end
        end
    end

    // ========================================================================
    // control for the current beat
    // ========================================================================
    always_comb begin
        ctrl.valid   = in_valid;
        ctrl.channel = chan_q;
        ctrl.beat    = beat_q;
        ctrl.last    = in_valid && beat_wrap && (chan_q == ch_blue);
    end

endmodule

`default_nettype wire

// ==== source/gray_buffer.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_buffer import isp_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  beat_idx_t rd_idx,
    input  logic      wr_en,
    input  beat_idx_t wr_idx,
    input  beat_t     wr_data,
    output beat_t     rd_data
);

    // one entry per beat of a plane
    beat_t mem [beats_per_channel];

    logic wr_ok;

    // no writes while held in reset
    assign wr_ok = wr_en & rst_n;

    // read is asynchronous, the lanes add it in the same cycle
    assign rd_data = mem[rd_idx];

    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[wr_idx] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/gray_lane.sv ====
`timescale 1ns/1ps
`default_nettype none

module gray_lane import isp_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  lane_ctrl_t ctrl,
    input  pixel_t     pix_in,
    input  pixel_t     partial,
    output pixel_t     gray
);

    pixel_t weighted;
    pixel_t next_gray;

    always_comb begin
        // green counts half, red and blue a quarter each
        if (ctrl.channel == ch_green) begin
            weighted = pix_in >> 1;
        end else begin
            weighted = pix_in >> 2;
        end

        // red opens a new pixel, later planes build on the stored value
        if (ctrl.channel == ch_red) begin
            next_gray = weighted;
        end else begin
            next_gray = partial + weighted;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            gray <= '0;
        end else if (ctrl.valid) begin
            gray <= next_gray;
        end
    end

endmodule

`default_nettype wire

// ==== source/isp_focus_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_focus_top import isp_pkg::*; #(
    parameter int win_row = 13,
    parameter int win_col = 10
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          in_valid,
    input  beat_t         in_data,
    output logic          out_valid,
    output focus_result_t out_focus
);

    lane_ctrl_t ctrl;
    lane_ctrl_t ctrl_q;
    beat_t      rd_beat;
    beat_t      gray_beat;

    // ========================================================================
    // position tracking
    // ========================================================================
    frame_sequencer u_seq (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .ctrl     (ctrl)
    );

    // control one cycle late, lined up with the lane registers
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl_q <= '0;
        end else begin
            ctrl_q <= ctrl;
        end
    end

    // ========================================================================
    // grey lanes and partial buffer
    // ========================================================================
    for (genvar i = 0; i < lanes; i++) begin : g_lane
        gray_lane u_lane (
            .clk     (clk),
            .rst_n   (rst_n),
            .ctrl    (ctrl),
            .pix_in  (in_data[i]),
            .partial (rd_beat[i]),
            .gray    (gray_beat[i])
        );
    end

    gray_buffer u_buf (
        .clk     (clk),
        .rst_n   (rst_n),
        .rd_idx  (ctrl.beat),
        .wr_en   (ctrl_q.valid),
        .wr_idx  (ctrl_q.beat),
        .wr_data (gray_beat),
        .rd_data (rd_beat)
    );

    focus_window #(
        .win_row (win_row),
        .win_col (win_col)
    ) u_focus (
        .clk       (clk),
        .rst_n     (rst_n),
        .ctrl      (ctrl_q),
        .gray_beat (gray_beat),
        .out_valid (out_valid),
        .out_focus (out_focus)
    );

endmodule

`default_nettype wire

// ==== source/isp_pkg.sv ====
`default_nettype none

package isp_pkg;

    // ========================================================================
    // picture geometry
    // ========================================================================
    localparam int lanes             = 16;
    localparam int beats_per_channel = 64;
    localparam int img_w             = 32;
    localparam int win_size          = 6;

    // ========================================================================
    // data types
    // ========================================================================
    typedef logic [7:0] pixel_t;

    // lane 0 sits in the low byte
    typedef pixel_t [lanes-1:0] beat_t;

    typedef logic [1:0] channel_t;
    typedef logic [$clog2(beats_per_channel)-1:0] beat_idx_t;
    typedef logic [15:0] contrast_t;

    localparam channel_t ch_red   = 2'd0;
    localparam channel_t ch_green = 2'd1;
    localparam channel_t ch_blue  = 2'd2;

    // per-beat control, shared by all lanes
    typedef struct packed {
        logic      valid;
        channel_t  channel;
        beat_idx_t beat;
        // final blue beat of the picture
        logic      last;
    } lane_ctrl_t;

    typedef struct packed {
        contrast_t contrast_2;
        contrast_t contrast_4;
        contrast_t contrast_6;
    } focus_result_t;

endpackage

`default_nettype wire

// ==== tb/isp_focus_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

module isp_focus_asserts import isp_pkg::*; (
    input logic       clk,
    input logic       rst_n,
    input logic       out_valid,
    input lane_ctrl_t ctrl
);

    // ========================================================================
    // result strobe
    // ========================================================================
    single_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid |=> !out_valid)
        else $error("out_valid stayed high for two cycles");

    quiet_in_reset: assert property (@(posedge clk) !rst_n |-> !out_valid)
        else $error("out_valid high during reset");

    // ========================================================================
    // sequencer control
    // ========================================================================
    // strobe rises two edges after the last beat, seen at the third sample
    result_after_last: assert property (@(posedge clk) disable iff (!rst_n)
        ctrl.last |-> ##3 out_valid)
        else $error("out_valid did not follow the last beat of the picture");

endmodule

`default_nettype wire

// ==== tb/tb_isp_focus.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_isp_focus import isp_pkg::*;;

    localparam int win_row    = 13;
    localparam int win_col    = 10;
    localparam int max_cycles = 1500;

    logic          clk = 1'b0;
    logic          rst_n;
    logic          in_valid;
    beat_t         in_data;
    logic          out_valid;
    focus_result_t out_focus;

    // [picture][channel][row][column]
    pixel_t      pics [2][3][32][32];
    logic [31:0] rand_state = 32'd43;
    int          cycles = 0;
    int          lat;

    isp_focus_top #(
        .win_row (win_row),
        .win_col (win_col)
    ) UUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .out_valid (out_valid),
        .out_focus (out_focus)
    );

    bind isp_focus_top isp_focus_asserts u_asserts (
        .clk       (clk),
        .rst_n     (rst_n),
        .out_valid (out_valid),
        .ctrl      (ctrl)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("simulation did not finish within %0d cycles", max_cycles);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    // ========================================================================
    // stimulus and reference helpers
    // ========================================================================
    function automatic logic [15:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state[31:16];
    endfunction

    function automatic int gray_at(int p, int r, int c);
        return int'(pics[p][0][r][c] >> 2) + int'(pics[p][1][r][c] >> 1)
             + int'(pics[p][2][r][c] >> 2);
    endfunction

    function automatic int abs_int(int v);
        return (v < 0) ? -v : v;
    endfunction

    // window-relative span lo..hi, both directions
    function automatic int contrast(int p, int lo, int hi);
        int sum;
        int rr;
        int cc;
        sum = 0;
        for (int r = lo; r <= hi; r++) begin
            for (int c = lo; c <= hi; c++) begin
                rr = win_row + r;
                cc = win_col + c;
                if (c < hi) sum += abs_int(gray_at(p, rr, cc) - gray_at(p, rr, cc + 1));
                if (r < hi) sum += abs_int(gray_at(p, rr, cc) - gray_at(p, rr + 1, cc));
            end
        end
        return sum;
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("ERROR %s expected %0d actual %0d", name, expected, actual);
            $display("Checks failed");
            $fatal(1, "stopping at first mismatch");
        end
    endtask

    task automatic fill_constant(input int p, input pixel_t v);
        for (int ch = 0; ch < 3; ch++)
            for (int r = 0; r < 32; r++)
                for (int c = 0; c < 32; c++) pics[p][ch][r][c] = v;
    endtask

    task automatic fill_random(input int p);
        for (int ch = 0; ch < 3; ch++)
            for (int r = 0; r < 32; r++)
                for (int c = 0; c < 32; c++) pics[p][ch][r][c] = pixel_t'(next_rand());
    endtask

    // hold leaves in_valid up so the next picture follows without a gap
    task automatic send_picture(input int p, input bit gaps, input bit hold);
        logic [15:0] r;
        int          idle;
        for (int ch = 0; ch < 3; ch++) begin
            for (int b = 0; b < beats_per_channel; b++) begin
                r = next_rand();
                if (gaps && r[1:0] == 2'd0) begin
                    idle = int'(r[3:2]) + 1;
                    repeat (idle) begin
                        @(negedge clk);
                        in_valid = 1'b0;
                    end
                end
                @(negedge clk);
                in_valid = 1'b1;
                for (int l = 0; l < lanes; l++) begin
                    in_data[l] = pics[p][ch][b / 2][(b % 2) * lanes + l];
                end
            end
        end
        if (!hold) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    // lat counts clock cycles from the edge that took the last beat
    task automatic collect_result(input string name, input int p, output int lat_out);
        lat_out = 0;
        do begin
            @(negedge clk);
            lat_out++;
        end while (!out_valid);
        check_value({name, " contrast_2"}, contrast(p, 2, 3), int'(out_focus.contrast_2));
        check_value({name, " contrast_4"}, contrast(p, 1, 4), int'(out_focus.contrast_4));
        check_value({name, " contrast_6"}, contrast(p, 0, 5), int'(out_focus.contrast_6));
    endtask

    // ========================================================================
    // directed tests
    // ========================================================================
    task automatic test_constant();
        fill_constant(0, 8'h5a);
        send_picture(0, 1'b0, 1'b0);
        collect_result("constant", 0, lat);
        check_value("constant contrast_6 zero", 0, int'(out_focus.contrast_6));
    endtask

    // red steps of 8 turn into grey steps of 2
    task automatic test_ramp();
        fill_constant(0, 8'h00);
        for (int r = 0; r < 32; r++)
            for (int c = 0; c < 32; c++) pics[0][0][r][c] = pixel_t'(8 * c);
        send_picture(0, 1'b0, 1'b0);
        collect_result("ramp", 0, lat);
        check_value("ramp contrast_2", 4, int'(out_focus.contrast_2));
        check_value("ramp contrast_4", 24, int'(out_focus.contrast_4));
        check_value("ramp contrast_6", 60, int'(out_focus.contrast_6));
    endtask

    task automatic test_random();
        fill_random(0);
        send_picture(0, 1'b0, 1'b0);
        collect_result("random", 0, lat);
    endtask

    task automatic test_gaps();
        fill_random(0);
        send_picture(0, 1'b1, 1'b0);
        collect_result("gaps", 0, lat);
        check_value("gaps latency", 2, lat);
    endtask

    task automatic test_back_to_back();
        fill_random(0);
        fill_random(1);
        fork
            begin
                send_picture(0, 1'b0, 1'b1);
                send_picture(1, 1'b0, 1'b0);
            end
            begin
                collect_result("back_to_back first", 0, lat);
                collect_result("back_to_back second", 1, lat);
            end
        join
    endtask

    initial begin
        rst_n    = 1'b0;
        in_valid = 1'b0;
        in_data  = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        test_constant();
        test_ramp();
        test_random();
        test_gaps();
        test_back_to_back();

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire
